//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module sensor_wrapper_tb \
  -f sensor_wrapper.f \
  -o sensor_sim

./obj_dir/sensor_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation finished cleanly"

//--- sensor_wrapper.f
src/sensor_wrapper_pkg.sv
src/sensor_axi_slave.sv
src/sensor_regs.sv
src/sensor_ctrl.sv
src/sensor_wrapper.sv
testbench/sensor_wrapper_tb.sv

//--- src/sensor_axi_slave.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_axi_slave (
  input  logic                           clk,
  input  logic                           rstn,
  // write address
  input  sensor_wrapper_pkg::axi_id_t    awid,
  input  sensor_wrapper_pkg::axi_addr_t  awaddr,
  input  sensor_wrapper_pkg::axi_len_t   awlen,
  input  sensor_wrapper_pkg::axi_size_t  awsize,
  input  sensor_wrapper_pkg::axi_burst_t awburst,
  input  logic                           awvalid,
  output logic                           awready,
  // write data
  input  sensor_wrapper_pkg::axi_data_t  wdata,
  input  logic                           wlast,
  input  logic                           wvalid,
  output logic                           wready,
  // write response
  output sensor_wrapper_pkg::axi_id_t    bid,
  output sensor_wrapper_pkg::axi_resp_t  bresp,
  output logic                           bvalid,
  input  logic                           bready,
  // read address
  input  sensor_wrapper_pkg::axi_id_t    arid,
  input  sensor_wrapper_pkg::axi_addr_t  araddr,
  input  sensor_wrapper_pkg::axi_len_t   arlen,
  input  sensor_wrapper_pkg::axi_size_t  arsize,
  input  sensor_wrapper_pkg::axi_burst_t arburst,
  input  logic                           arvalid,
  output logic                           arready,
  // read data
  output sensor_wrapper_pkg::axi_id_t    rid,
  output sensor_wrapper_pkg::axi_data_t  rdata,
  output sensor_wrapper_pkg::axi_resp_t  rresp,
  output logic                           rlast,
  output logic                           rvalid,
  input  logic                           rready,
  // register and buffer side
  output logic                           reg_we,
  output sensor_wrapper_pkg::word_addr_t reg_addr,
  output logic                           reg_wbit,
  output sensor_wrapper_pkg::buf_idx_t   buf_addr,
  input  sensor_wrapper_pkg::axi_data_t  buf_rdata
);
  import sensor_wrapper_pkg::*;

  slave_state_t state, state_nxt;

  axi_id_t    id_r;
  axi_len_t   len_r;
  axi_size_t  size_r;
  axi_burst_t burst_r;
  axi_addr_t  addr_r;
  axi_len_t   beat_cnt;
  axi_addr_t  beat_addr;

  logic aw_hs, ar_hs, w_hs, r_hs, b_hs;

  assign aw_hs = awvalid & awready;
  assign ar_hs = arvalid & arready;
  assign w_hs  = wvalid & wready;
  assign r_hs  = rvalid & rready;
  assign b_hs  = bvalid & bready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (aw_hs) begin
          state_nxt = WRITE;
        end else if (ar_hs) begin
          state_nxt = READ;
        end
      end
      WRITE: begin
        if (w_hs && wlast) begin
          state_nxt = WRESP;
        end
      end
      WRESP: begin
        if (b_hs) begin
          state_nxt = IDLE;
        end
      end
      READ: begin
        if (r_hs && rlast) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  assign awready = (state == IDLE);
  assign arready = (state == IDLE) & ~awvalid;  // write wins a tie
  assign wready  = (state == WRITE);
  assign bvalid  = (state == WRESP);
  assign rvalid  = (state == READ);

  // request fields, held for the whole burst
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_r    <= awid;
      len_r   <= awlen;
      size_r  <= awsize;
      burst_r <= awburst;
      addr_r  <= awaddr;
    end else if (ar_hs) begin
      id_r    <= arid;
      len_r   <= arlen;
      size_r  <= arsize;
      burst_r <= arburst;
      addr_r  <= araddr;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt <= '0;
    end else if ((w_hs && wlast) || (r_hs && rlast)) begin
      beat_cnt <= '0;
    end else if (w_hs || r_hs) begin
      beat_cnt <= beat_cnt + axi_len_t'(1);
    end
  end

  always_comb begin
    case (burst_r)
      BURST_INCR:  beat_addr = addr_r + (axi_addr_t'(beat_cnt) << size_r);
      BURST_FIXED: beat_addr = addr_r;
      default:     beat_addr = addr_r;  // wrap behaves as fixed
    endcase
  end

  assign reg_addr = beat_addr[11:2];
  assign buf_addr = reg_addr[5:0];
  assign reg_we   = w_hs;
  assign reg_wbit = wdata[0];

  assign bid   = id_r;
  assign bresp = RESP_OKAY;
  assign rid   = id_r;
  assign rdata = buf_rdata;
  assign rresp = RESP_OKAY;
  assign rlast = rvalid & (beat_cnt == len_r);

  a_rbeat_in_range: assert property (@(posedge clk) disable iff (!rstn)
    rvalid |-> beat_cnt <= len_r);

  a_wlast_on_count: assert property (@(posedge clk) disable iff (!rstn)
    w_hs |-> (wlast == (beat_cnt == len_r)));

endmodule

`default_nettype wire

//--- src/sensor_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_ctrl (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          sctrl_en,
  input  logic                          sctrl_clear,
  input  logic                          sensor_ready,
  input  sensor_wrapper_pkg::axi_data_t sensor_out,
  input  sensor_wrapper_pkg::buf_idx_t  buf_addr,
  output logic                          sensor_en,
  output logic                          sensor_interrupt,
  output sensor_wrapper_pkg::axi_data_t buf_rdata
);
  import sensor_wrapper_pkg::*;

  localparam int CNT_W = $clog2(BUF_DEPTH) + 1;

  axi_data_t sample_buf [BUF_DEPTH];

  logic [CNT_W-1:0] fill_cnt;
  logic [CNT_W-1:0] fill_nxt;
  logic             full;
  logic             capture;

  assign full      = (fill_cnt == CNT_W'(BUF_DEPTH));
  assign sensor_en = sctrl_en & ~full & ~sctrl_clear;
  assign capture   = sensor_en & sensor_ready;
  assign fill_nxt  = fill_cnt + CNT_W'(capture);

  // sample store, indexed by fill position
  always_ff @(posedge clk) begin
    if (capture) begin
      sample_buf[buf_idx_t'(fill_cnt)] <= sensor_out;
    end
  end

  assign buf_rdata = sample_buf[buf_addr];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fill_cnt <= '0;
    end else if (sctrl_clear) begin
      fill_cnt <= '0;  // restart from index 0
    end else begin
      fill_cnt <= fill_nxt;
    end
  end

  // set together with the last stored sample
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sensor_interrupt <= 1'b0;
    end else if (sctrl_clear) begin
      sensor_interrupt <= 1'b0;
    end else if (fill_nxt == CNT_W'(BUF_DEPTH)) begin
      sensor_interrupt <= 1'b1;
    end
  end

  a_fill_bound: assert property (@(posedge clk) disable iff (!rstn)
    fill_cnt <= CNT_W'(BUF_DEPTH));

endmodule

`default_nettype wire

//--- src/sensor_regs.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_regs (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           reg_we,
  input  sensor_wrapper_pkg::word_addr_t reg_addr,
  input  logic                           reg_wbit,
  output logic                           sctrl_en,
  output logic                           sctrl_clear
);
  import sensor_wrapper_pkg::*;

  logic hit_en, hit_clear;

  assign hit_en    = (reg_addr == SCTRL_ENB_ADDR);
  assign hit_clear = (reg_addr == SCTRL_CLEAR_ADDR);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sctrl_en    <= 1'b0;
      sctrl_clear <= 1'b0;
    end else if (reg_we) begin
      if (hit_en) begin
        sctrl_en <= reg_wbit;
      end
      if (hit_clear) begin
        sctrl_clear <= reg_wbit;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/sensor_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_wrapper (
  input  logic                           clk,
  input  logic                           rstn,
  input  sensor_wrapper_pkg::axi_id_t    awid,
  input  sensor_wrapper_pkg::axi_addr_t  awaddr,
  input  sensor_wrapper_pkg::axi_len_t   awlen,
  input  sensor_wrapper_pkg::axi_size_t  awsize,
  input  sensor_wrapper_pkg::axi_burst_t awburst,
  input  logic                           awvalid,
  output logic                           awready,
  input  sensor_wrapper_pkg::axi_data_t  wdata,
  input  logic                           wlast,
  input  logic                           wvalid,
  output logic                           wready,
  output sensor_wrapper_pkg::axi_id_t    bid,
  output sensor_wrapper_pkg::axi_resp_t  bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  sensor_wrapper_pkg::axi_id_t    arid,
  input  sensor_wrapper_pkg::axi_addr_t  araddr,
  input  sensor_wrapper_pkg::axi_len_t   arlen,
  input  sensor_wrapper_pkg::axi_size_t  arsize,
  input  sensor_wrapper_pkg::axi_burst_t arburst,
  input  logic                           arvalid,
  output logic                           arready,
  output sensor_wrapper_pkg::axi_id_t    rid,
  output sensor_wrapper_pkg::axi_data_t  rdata,
  output sensor_wrapper_pkg::axi_resp_t  rresp,
  output logic                           rlast,
  output logic                           rvalid,
  input  logic                           rready,
  // sensor pins
  input  logic                           sensor_ready,
  input  sensor_wrapper_pkg::axi_data_t  sensor_out,
  output logic                           sensor_en,
  output logic                           sensor_interrupt
);
  import sensor_wrapper_pkg::*;

  logic       reg_we;
  word_addr_t reg_addr;
  logic       reg_wbit;
  buf_idx_t   buf_addr;
  axi_data_t  buf_rdata;
  logic       sctrl_en;
  logic       sctrl_clear;

  sensor_axi_slave u_slave (
    .clk       (clk),
    .rstn      (rstn),
    .awid      (awid),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .awsize    (awsize),
    .awburst   (awburst),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wlast     (wlast),
    .wvalid    (wvalid),
    .wready    (wready),
    .bid       (bid),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .arid      (arid),
    .araddr    (araddr),
    .arlen     (arlen),
    .arsize    (arsize),
    .arburst   (arburst),
    .arvalid   (arvalid),
    .arready   (arready),
    .rid       (rid),
    .rdata     (rdata),
    .rresp     (rresp),
    .rlast     (rlast),
    .rvalid    (rvalid),
    .rready    (rready),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wbit  (reg_wbit),
    .buf_addr  (buf_addr),
    .buf_rdata (buf_rdata)
  );

  sensor_regs u_regs (
    .clk         (clk),
    .rstn        (rstn),
    .reg_we      (reg_we),
    .reg_addr    (reg_addr),
    .reg_wbit    (reg_wbit),
    .sctrl_en    (sctrl_en),
    .sctrl_clear (sctrl_clear)
  );

  sensor_ctrl u_ctrl (
    .clk              (clk),
    .rstn             (rstn),
    .sctrl_en         (sctrl_en),
    .sctrl_clear      (sctrl_clear),
    .sensor_ready     (sensor_ready),
    .sensor_out       (sensor_out),
    .buf_addr         (buf_addr),
    .sensor_en        (sensor_en),
    .sensor_interrupt (sensor_interrupt),
    .buf_rdata        (buf_rdata)
  );

endmodule

`default_nettype wire

//--- src/sensor_wrapper_pkg.sv
`default_nettype none

package sensor_wrapper_pkg;

  // AXI field types
  typedef logic [31:0] axi_addr_t;   // byte address
  typedef logic [31:0] axi_data_t;   // bus word, also one sensor sample
  typedef logic [7:0]  axi_id_t;
  typedef logic [7:0]  axi_len_t;    // beats minus one
  typedef logic [2:0]  axi_size_t;
  typedef logic [1:0]  axi_burst_t;
  typedef logic [1:0]  axi_resp_t;

  // local addressing
  typedef logic [9:0]  word_addr_t;  // byte address bits 11:2
  typedef logic [5:0]  buf_idx_t;

  // slave transaction phases
  typedef enum logic [1:0] {
    IDLE,
    READ,
    WRITE,
    WRESP
  } slave_state_t;

  localparam axi_burst_t BURST_FIXED = 2'b00;
  localparam axi_burst_t BURST_INCR  = 2'b01;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  localparam int BUF_DEPTH = 64;  // samples per capture

  // control register word addresses
  localparam word_addr_t SCTRL_ENB_ADDR   = 10'h100;
  localparam word_addr_t SCTRL_CLEAR_ADDR = 10'h200;

endpackage

`default_nettype wire

//--- testbench/sensor_wrapper_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_wrapper_tb;
  import sensor_wrapper_pkg::*;

  localparam int NROWS   = 9;
  localparam int TIMEOUT = 2000;  // cycles per wait

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT_IRQ} op_t;

  typedef struct packed {
    op_t        op;
    word_addr_t addr;
    axi_len_t   len;
    axi_burst_t burst;
    logic       wbit;
    logic       rand_rdy;  // toggle rready during the read
    logic       exp_en;
    logic       exp_irq;
  } row_t;

  logic       clk = 1'b0;
  logic       rstn;
  axi_id_t    awid, bid, arid, rid;
  axi_addr_t  awaddr, araddr;
  axi_len_t   awlen, arlen;
  axi_size_t  awsize, arsize;
  axi_burst_t awburst, arburst;
  axi_resp_t  bresp, rresp;
  axi_data_t  wdata, rdata, sensor_out;
  logic       awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rlast, rvalid, rready;
  logic       sensor_ready, sensor_en, sensor_interrupt;

  row_t      rows [NROWS];
  string     names [NROWS];
  axi_data_t model_buf [BUF_DEPTH];
  int        model_fill;

  sensor_wrapper uut (.*);

  always #5 clk = ~clk;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timed out while waiting for %s", what);
    $display("=== FAIL ===");
    $fatal(1, "wait timed out");
  endtask

  task automatic set_row(input int i, input string name, input op_t op, input word_addr_t addr,
                         input axi_len_t len, input axi_burst_t burst, input logic wbit,
                         input logic rand_rdy, input logic exp_en, input logic exp_irq);
    names[i] = name;
    rows[i]  = '{op, addr, len, burst, wbit, rand_rdy, exp_en, exp_irq};
  endtask

  task automatic build_table();
    set_row(0, "enable", OP_WRITE, SCTRL_ENB_ADDR, 8'd0, BURST_INCR, 1, 0, 1, 0);
    set_row(1, "first fill", OP_WAIT_IRQ, 10'd0, 8'd0, BURST_INCR, 0, 0, 0, 1);
    set_row(2, "incr read", OP_READ, 10'd8, 8'd15, BURST_INCR, 0, 0, 0, 1);
    set_row(3, "incr read backpressure", OP_READ, 10'd8, 8'd15, BURST_INCR, 0, 1, 0, 1);
    set_row(4, "fixed read", OP_READ, 10'd5, 8'd3, BURST_FIXED, 0, 0, 0, 1);
    set_row(5, "clear set", OP_WRITE, SCTRL_CLEAR_ADDR, 8'd0, BURST_INCR, 1, 0, 0, 0);
    set_row(6, "clear release", OP_WRITE, SCTRL_CLEAR_ADDR, 8'd0, BURST_INCR, 0, 0, 1, 0);
    set_row(7, "second fill", OP_WAIT_IRQ, 10'd0, 8'd0, BURST_INCR, 0, 0, 0, 1);
    set_row(8, "refill read", OP_READ, 10'd0, 8'd3, BURST_INCR, 0, 1, 0, 1);
  endtask

  // strobes every 2 to 4 cycles while capture is on
  task automatic sensor_model();
    int        gap;
    axi_data_t sample;
    forever begin
      @(posedge clk);
      #1;
      if (sensor_en === 1'b1 && model_fill < BUF_DEPTH) begin
        sample       = $urandom;
        sensor_out   = sample;
        sensor_ready = 1'b1;
        model_buf[model_fill] = sample;
        model_fill++;
        gap = 2 + int'($urandom % 3);
        @(posedge clk);
        #1;
        sensor_ready = 1'b0;
        repeat (gap - 2) @(posedge clk);
      end
    end
  endtask

  task automatic write_burst(input string name, input axi_id_t id, input row_t r);
    int n;
    awid    = id;
    awaddr  = axi_addr_t'(r.addr) << 2;
    awlen   = r.len;
    awsize  = 3'd2;
    awburst = r.burst;
    awvalid = 1'b1;
    n = 0;
    while (!awready) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) timeout_fail("awready");
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    for (int b = 0; b <= int'(r.len); b++) begin
      wdata  = axi_data_t'(r.wbit);
      wlast  = (b == int'(r.len));
      wvalid = 1'b1;
      n = 0;
      while (!wready) begin
        @(posedge clk);
        #1;
        n++;
        if (n > TIMEOUT) timeout_fail("wready");
      end
      @(posedge clk);
      #1;
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    bready = 1'b1;
    n = 0;
    while (!bvalid) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) timeout_fail("bvalid");
    end
    check({name, " bid"}, 32'(id), 32'(bid));
    check({name, " bresp"}, 32'(RESP_OKAY), 32'(bresp));
    @(posedge clk);
    #1;
    bready = 1'b0;
    check({name, " sensor_en"}, 32'(r.exp_en), 32'(sensor_en));
    check({name, " sensor_interrupt"}, 32'(r.exp_irq), 32'(sensor_interrupt));
    if (r.addr == SCTRL_CLEAR_ADDR && r.wbit) model_fill = 0;  // refill starts at index 0
  endtask

  task automatic read_burst(input string name, input axi_id_t id, input row_t r);
    int n;
    int widx;
    arid    = id;
    araddr  = axi_addr_t'(r.addr) << 2;
    arlen   = r.len;
    arsize  = 3'd2;
    arburst = r.burst;
    arvalid = 1'b1;
    n = 0;
    while (!arready) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) timeout_fail("arready");
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    for (int b = 0; b <= int'(r.len); b++) begin
      widx   = (r.burst == BURST_INCR) ? int'(r.addr) + b : int'(r.addr);
      rready = r.rand_rdy ? 1'($urandom) : 1'b1;
      n = 0;
      while (!(rvalid && rready)) begin
        @(posedge clk);
        #1;
        rready = r.rand_rdy ? 1'($urandom) : 1'b1;
        n++;
        if (n > TIMEOUT) timeout_fail("read beat");
      end
      check($sformatf("%s beat %0d rdata", name, b), model_buf[widx % BUF_DEPTH], rdata);
      check($sformatf("%s beat %0d rid", name, b), 32'(id), 32'(rid));
      check($sformatf("%s beat %0d rlast", name, b), 32'(b == int'(r.len)), 32'(rlast));
      check($sformatf("%s beat %0d rresp", name, b), 32'(RESP_OKAY), 32'(rresp));
      @(posedge clk);
      #1;
    end
    rready = 1'b0;
    check({name, " rvalid after burst"}, 32'd0, 32'(rvalid));
  endtask

  task automatic wait_irq(input string name, input row_t r);
    int n;
    n = 0;
    while (!sensor_interrupt) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) timeout_fail("sensor_interrupt");
    end
    @(posedge clk);  // a level, still set one cycle on
    #1;
    check({name, " sensor_interrupt"}, 32'(r.exp_irq), 32'(sensor_interrupt));
    check({name, " sensor_en"}, 32'(r.exp_en), 32'(sensor_en));
    check({name, " samples"}, 32'(BUF_DEPTH), 32'(model_fill));
  endtask

  initial begin
    void'($urandom(51368));
    rstn = 1'b0;
    awid = '0;
    awaddr = '0;
    awlen = '0;
    awsize = '0;
    awburst = '0;
    awvalid = 1'b0;
    wdata = '0;
    wlast = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arid = '0;
    araddr = '0;
    arlen = '0;
    arsize = '0;
    arburst = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    sensor_ready = 1'b0;
    sensor_out   = '0;
    model_fill   = 0;
    build_table();
    fork
      sensor_model();
    join_none
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    check("reset sensor_en", 32'd0, 32'(sensor_en));
    check("reset sensor_interrupt", 32'd0, 32'(sensor_interrupt));
    check("reset rvalid", 32'd0, 32'(rvalid));
    check("reset bvalid", 32'd0, 32'(bvalid));
    check("reset awready", 32'd1, 32'(awready));
    check("reset arready", 32'd1, 32'(arready));
    for (int i = 0; i < NROWS; i++) begin
      case (rows[i].op)
        OP_WRITE:    write_burst(names[i], axi_id_t'(i + 32), rows[i]);
        OP_READ:     read_burst(names[i], axi_id_t'(i + 32), rows[i]);
        OP_WAIT_IRQ: wait_irq(names[i], rows[i]);
        default:     timeout_fail("a known table operation");
      endcase
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
